// ==== design/ex_stage.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module ex_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  id_ex_t              id_ex_i,
    input  ex_wb_t              wb_i,
    output ex_wb_t              ex_wb_o,
    output logic                redirect_o,
    output logic [`RV_XLEN-1:0] target_o
);

    logic [`RV_XLEN-1:0] op_a, fwd_b, op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic                fwd_a_hit, fwd_b_hit;
    logic                equal, taken;

    // ------------------------------
    // forwarding from ex/wb
    // ------------------------------
    assign fwd_a_hit = wb_i.reg_write && wb_i.rd != '0 && wb_i.rd == id_ex_i.rs1;
    assign fwd_b_hit = wb_i.reg_write && wb_i.rd != '0 && wb_i.rd == id_ex_i.rs2;

    assign op_a  = fwd_a_hit ? wb_i.result : id_ex_i.rs1_data;
    assign fwd_b = fwd_b_hit ? wb_i.result : id_ex_i.rs2_data;
    assign op_b  = id_ex_i.use_imm ? id_ex_i.imm : fwd_b;

    // ------------------------------
    // alu
    // ------------------------------
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // ------------------------------
    // branch / jump
    // ------------------------------
    assign equal = (op_a == fwd_b);      // register operands, never imm
    assign taken = id_ex_i.is_branch && (equal != id_ex_i.branch_ne);

    assign redirect_o = id_ex_i.is_jal || taken;
    assign target_o   = id_ex_i.pc_imm;

    assign ex_wb_o.reg_write = id_ex_i.reg_write;
    assign ex_wb_o.rd        = id_ex_i.rd;
    assign ex_wb_o.result    = id_ex_i.is_jal ? id_ex_i.pc_plus4 : alu_res; // link addr

endmodule

// ==== design/fetch_pc.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module fetch_pc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_i,
    input  logic                redirect_i,
    input  logic [`RV_XLEN-1:0] target_i,
    output logic [`RV_XLEN-1:0] pc_o
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_o <= `RV_RESET_PC;
        end else if (!stall_i) begin
            if (redirect_i) begin
                pc_o <= target_i;     // taken branch or jal
            end else begin
                pc_o <= pc_o + `RV_XLEN'd4;
            end
        end
    end

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module id_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  if_id_t              if_id_i,
    input  logic [`RV_XLEN-1:0] rdata1_i,
    input  logic [`RV_XLEN-1:0] rdata2_i,
    output reg_addr_t           raddr1_o,
    output reg_addr_t           raddr2_o,
    output id_ex_t              id_ex_o
);

    logic [31:0]         ins;
    instr_t              f;
    logic [`RV_XLEN-1:0] imm_i, imm_u, imm_b, imm_j;

    assign ins = if_id_i.instr;
    assign f   = instr_t'(ins);

    assign raddr1_o = f.rs1;
    assign raddr2_o = f.rs2;

    // ------------------------------
    // immediates
    // ------------------------------
    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    // ------------------------------
    // decode
    // ------------------------------
    always_comb begin : decode
        alu_op_e alu;
        logic    alu_ok;

        alu    = ALU_ADD;
        alu_ok = 1'b1;
        case (f.funct3)
            F3_ADD_SUB: alu = (f.opcode == OP && f.funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu = ALU_SLL;
            F3_SLT:     alu = ALU_SLT;
            F3_XOR:     alu = ALU_XOR;
            F3_SRL:     alu = ALU_SRL;
            F3_OR:      alu = ALU_OR;
            F3_AND:     alu = ALU_AND;
            default:    alu_ok = 1'b0;     // sltu
        endcase
        if (f.funct3 == F3_SRL && f.funct7[5]) begin
            alu_ok = 1'b0;                 // no arithmetic shift
        end

        id_ex_o          = '0;             // bubble unless decoded
        id_ex_o.rs1_data = rdata1_i;
        id_ex_o.rs2_data = rdata2_i;
        id_ex_o.pc_plus4 = if_id_i.pc + `RV_XLEN'd4;

        case (f.opcode)
            OP, OP_IMM: if (alu_ok) begin
                id_ex_o.alu_op  = alu;
                id_ex_o.use_imm = (f.opcode == OP_IMM);
                id_ex_o.imm     = imm_i;
                id_ex_o.rs1     = f.rs1;
                id_ex_o.rs2     = (f.opcode == OP) ? f.rs2 : '0;
                id_ex_o.rd      = f.rd;
            end
            LUI: begin
                id_ex_o.alu_op  = ALU_PASS_B;
                id_ex_o.use_imm = 1'b1;
                id_ex_o.imm     = imm_u;
                id_ex_o.rd      = f.rd;
            end
            BRANCH: if (f.funct3 == F3_BEQ || f.funct3 == F3_BNE) begin
                id_ex_o.is_branch = 1'b1;
                id_ex_o.branch_ne = f.funct3[0];
                id_ex_o.imm       = imm_b;
                id_ex_o.rs1       = f.rs1;
                id_ex_o.rs2       = f.rs2;
            end
            JAL: begin
                id_ex_o.is_jal = 1'b1;
                id_ex_o.imm    = imm_j;
                id_ex_o.rd     = f.rd;
            end
            default: ;
        endcase

        id_ex_o.pc_imm    = if_id_i.pc + id_ex_o.imm;
        id_ex_o.reg_write = (id_ex_o.rd != '0);    // x0 never written back
    end

endmodule

// ==== design/pipe_reg.sv ====
`timescale 1ns/1ps

// stage register, stall beats flush
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (stall_i) begin
            q_o <= q_o;           // hold
        end else if (flush_i) begin
            q_o <= '0;            // bubble
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module reg_file
    import rv_isa_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we_i,
    input  reg_addr_t           waddr_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    input  reg_addr_t           raddr1_i,
    input  reg_addr_t           raddr2_i,
    output logic [`RV_XLEN-1:0] rdata1_o,
    output logic [`RV_XLEN-1:0] rdata2_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, same-cycle write bypassed
    assign rdata1_o = (raddr1_i == '0)                 ? '0      :
                      (we_i && waddr_i == raddr1_i)    ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                 ? '0      :
                      (we_i && waddr_i == raddr2_i)    ? wdata_i : regs[raddr2_i];

endmodule

// ==== design/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ------------------------------
// core-wide sizes
// ------------------------------

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== design/rv_exec_core.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_exec_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_i,
    input  logic [31:0]         instr_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic                redirect_o,
    output logic                wb_en_o,
    output reg_addr_t           wb_rd_o,
    output logic [`RV_XLEN-1:0] wb_data_o
);

    if_id_t              if_id_d, if_id_q;
    id_ex_t              id_ex_d, id_ex_q;
    ex_wb_t              ex_wb_d, ex_wb_q;
    reg_addr_t           raddr1, raddr2;
    logic [`RV_XLEN-1:0] rdata1, rdata2;
    logic [`RV_XLEN-1:0] target;
    logic                rf_we;

    assign if_id_d.instr = instr_i;
    assign if_id_d.pc    = pc_o;

    // no register write while the pipe is frozen
    assign rf_we = ex_wb_q.reg_write && !stall_i;

    assign wb_en_o   = ex_wb_q.reg_write;
    assign wb_rd_o   = ex_wb_q.rd;
    assign wb_data_o = ex_wb_q.result;

    fetch_pc u_fetch_pc (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i),
        .redirect_i(redirect_o), .target_i(target), .pc_o(pc_o)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .flush_i(redirect_o),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    id_stage u_id_stage (
        .if_id_i(if_id_q), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .id_ex_o(id_ex_d)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .we_i(rf_we), .waddr_i(ex_wb_q.rd), .wdata_i(ex_wb_q.result),
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .flush_i(redirect_o),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    ex_stage u_ex_stage (
        .id_ex_i(id_ex_q), .wb_i(ex_wb_q), .ex_wb_o(ex_wb_d),
        .redirect_o(redirect_o), .target_o(target)
    );

    // last stage, never flushed
    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .flush_i(1'b0),
        .d_i(ex_wb_d), .q_o(ex_wb_q)
    );

endmodule

// ==== design/rv_isa_pkg.sv ====
`include "rv_defs.svh"

package rv_isa_pkg;

    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

    // major opcodes, subset only
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8     // lui
    } alu_op_e;

    // r-type field split, other formats reuse it
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } instr_t;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

endpackage

// ==== design/rv_pipe_pkg.sv ====
`include "rv_defs.svh"

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // ------------------------------
    // fetch -> decode
    // ------------------------------
    typedef struct packed {
        logic [31:0]         instr;
        logic [`RV_XLEN-1:0] pc;
    } if_id_t;

    // ------------------------------
    // decode -> execute
    // ------------------------------
    // all zero is a bubble
    typedef struct packed {
        // control
        alu_op_e             alu_op;
        logic                use_imm;
        logic                reg_write;
        logic                is_branch;
        logic                is_jal;
        logic                branch_ne;    // funct3[0]
        // data
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] pc_plus4;
        logic [`RV_XLEN-1:0] pc_imm;       // branch / jal target
        // register addresses
        reg_addr_t           rs1;
        reg_addr_t           rs2;
        reg_addr_t           rd;
    } id_ex_t;

    // ------------------------------
    // execute -> writeback
    // ------------------------------
    typedef struct packed {
        logic                reg_write;
        reg_addr_t           rd;
        logic [`RV_XLEN-1:0] result;
    } ex_wb_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f rv_exec_core.f \
    --top-module rv_exec_core_tb \
    --Mdir obj_dir -o sim_rv_exec_core

./obj_dir/sim_rv_exec_core > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== rv_exec_core.f ====
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/pipe_reg.sv
design/fetch_pc.sv
design/reg_file.sv
design/id_stage.sv
design/ex_stage.sv
design/rv_exec_core.sv
tests/rv_exec_core_sva.sv
tests/rv_exec_core_tb.sv

// ==== tests/rv_exec_core_sva.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_exec_core_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                stall_i,
    input logic                redirect_o,
    input logic                wb_en_o,
    input logic [4:0]          wb_rd_o,
    input logic [`RV_XLEN-1:0] wb_data_o,
    input logic [`RV_XLEN-1:0] pc_o
);

    logic [1:0] squash_cnt;     // 2 and 1 mark the squashed slots

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            squash_cnt <= '0;
        end else if (!stall_i) begin
            if (redirect_o) squash_cnt <= 2'd3;
            else if (squash_cnt != '0) squash_cnt <= squash_cnt - 2'd1;
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable(wb_en_o) && $stable(wb_rd_o) && $stable(wb_data_o)
                    && $stable(pc_o))
        else $error("outputs moved during a stall");

    a_squash: assert property (@(posedge clk) disable iff (!rst_n)
        (squash_cnt == 2'd2 || squash_cnt == 2'd1) |-> !wb_en_o)
        else $error("writeback from a squashed instruction");

    a_no_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en_o |-> wb_rd_o != '0)
        else $error("writeback to x0");

endmodule

bind rv_exec_core rv_exec_core_sva u_sva (.*);

// ==== tests/rv_exec_core_tb.sv ====
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_exec_core_tb;

    localparam int PROG_LEN = 28;
    localparam int N_EXP    = 20;
    localparam int N_TGT    = 3;
    localparam int DRAIN    = 24;               // cycles watched after the last writeback
    localparam int MAX_CYC  = 8 + PROG_LEN * 4 + 100;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] val;
    } wb_exp_t;

    logic                clk;
    logic                rst_n;
    logic                stall_i;
    logic [31:0]         instr_i;
    logic [`RV_XLEN-1:0] pc_o;
    logic                redirect_o;
    logic                wb_en_o;
    logic [4:0]          wb_rd_o;
    logic [`RV_XLEN-1:0] wb_data_o;

    logic [31:0] prog    [PROG_LEN];
    wb_exp_t     exp_wb  [N_EXP];
    logic [31:0] exp_tgt [N_TGT];

    integer seed;
    int     wb_idx;
    int     tgt_idx;
    logic   redir_pend;
    int     errors;
    int     checks;
    int     drain;

    rv_exec_core dut (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .instr_i(instr_i),
        .pc_o(pc_o), .redirect_o(redirect_o), .wb_en_o(wb_en_o),
        .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // combinational instruction memory returns zero past the program
    always_comb begin
        if (pc_o[31:2] < PROG_LEN) instr_i = prog[pc_o[31:2]];
        else instr_i = 32'h0;
    end

    // ------------------------------
    // instruction encoders
    // ------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic load_tables();
        prog[0]  = enc_i(12'd5, 5'd0, 3'b000, 5'd1);          // addi x1, x0, 5
        prog[1]  = enc_i(-12'sd3, 5'd0, 3'b000, 5'd2);        // addi x2, x0, -3
        prog[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);    // add
        prog[3]  = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);    // sub
        prog[4]  = enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);    // and
        prog[5]  = enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);    // or
        prog[6]  = enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);    // xor
        prog[7]  = enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);    // slt x8, x2, x1
        prog[8]  = enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd9);    // sll
        prog[9]  = enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd10);   // srl
        prog[10] = enc_i(12'h0f0, 5'd2, 3'b111, 5'd11);       // andi
        prog[11] = enc_i(12'h100, 5'd1, 3'b110, 5'd12);       // ori
        prog[12] = enc_i(12'hfff, 5'd1, 3'b100, 5'd13);       // xori -1
        prog[13] = enc_i(12'd6, 5'd1, 3'b010, 5'd14);         // slti
        prog[14] = enc_i(12'd4, 5'd1, 3'b001, 5'd15);         // slli
        prog[15] = enc_i(12'd28, 5'd2, 3'b101, 5'd16);        // srli
        prog[16] = {20'h12345, 5'd17, OPC_LUI};
        prog[17] = enc_i(12'h678, 5'd17, 3'b000, 5'd17);      // dependent on lui
        prog[18] = enc_b(13'd8, 5'd2, 5'd1, 3'b000);          // beq not taken
        prog[19] = enc_b(13'd12, 5'd2, 5'd1, 3'b001);         // bne to 88
        prog[20] = enc_i(12'd1, 5'd0, 3'b000, 5'd20);         // squashed
        prog[21] = enc_i(12'd1, 5'd0, 3'b000, 5'd21);         // squashed
        prog[22] = enc_j(21'd12, 5'd22);                      // jal to 100
        prog[23] = enc_i(12'd1, 5'd0, 3'b000, 5'd23);         // squashed
        prog[24] = enc_i(12'd1, 5'd0, 3'b000, 5'd24);         // squashed
        prog[25] = enc_r(7'h00, 5'd3, 5'd22, 3'b000, 5'd25);  // add x25, x22, x3
        prog[26] = enc_i(12'd7, 5'd1, 3'b000, 5'd0);          // addi x0 gives no writeback
        prog[27] = enc_b(13'd0, 5'd0, 5'd0, 3'b000);          // spin here

        // expected writebacks in program order
        exp_wb[0]  = {5'd1,  32'h0000_0005};
        exp_wb[1]  = {5'd2,  32'hffff_fffd};
        exp_wb[2]  = {5'd3,  32'h0000_0002};
        exp_wb[3]  = {5'd4,  32'h0000_0008};
        exp_wb[4]  = {5'd5,  32'h0000_0005};
        exp_wb[5]  = {5'd6,  32'hffff_fffd};
        exp_wb[6]  = {5'd7,  32'hffff_fff8};
        exp_wb[7]  = {5'd8,  32'h0000_0001};
        exp_wb[8]  = {5'd9,  32'h0000_00a0};
        exp_wb[9]  = {5'd10, 32'h07ff_ffff};
        exp_wb[10] = {5'd11, 32'h0000_00f0};
        exp_wb[11] = {5'd12, 32'h0000_0105};
        exp_wb[12] = {5'd13, 32'hffff_fffa};
        exp_wb[13] = {5'd14, 32'h0000_0001};
        exp_wb[14] = {5'd15, 32'h0000_0050};
        exp_wb[15] = {5'd16, 32'h0000_000f};
        exp_wb[16] = {5'd17, 32'h1234_5000};
        exp_wb[17] = {5'd17, 32'h1234_5678};
        exp_wb[18] = {5'd22, 32'h0000_005c};   // link = 88 + 4
        exp_wb[19] = {5'd25, 32'h0000_005e};

        // pc expected after each redirect
        exp_tgt[0] = 32'd88;
        exp_tgt[1] = 32'd100;
        exp_tgt[2] = 32'd108;    // spin loop repeats this one
    endtask

    task automatic check_writeback();
        if (wb_idx >= N_EXP) begin
            $display("unexpected writeback to x%0d after the expected table ran out at %0t",
                     wb_rd_o, $time);
            errors++;
        end else begin
            checks++;
            if (wb_rd_o !== exp_wb[wb_idx].rd) begin
                $display("[ERROR] %0t wb_rd_o expected %0d actual %0d",
                         $time, exp_wb[wb_idx].rd, wb_rd_o);
                errors++;
            end
            if (wb_data_o !== exp_wb[wb_idx].val) begin
                $display("[ERROR] %0t wb_data_o expected %h actual %h",
                         $time, exp_wb[wb_idx].val, wb_data_o);
                errors++;
            end
            wb_idx++;
        end
    endtask

    task automatic check_redirect();
        logic [31:0] exp_pc;

        exp_pc = exp_tgt[(tgt_idx < N_TGT) ? tgt_idx : N_TGT - 1];
        checks++;
        if (pc_o !== exp_pc) begin
            $display("[ERROR] %0t pc_o after redirect expected %h actual %h",
                     $time, exp_pc, pc_o);
            errors++;
        end
        tgt_idx++;
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        #(MAX_CYC * 100);
        $display("watchdog expired before the run finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed       = 32'h28407471;
        rst_n      = 1'b0;
        stall_i    = 1'b0;
        wb_idx     = 0;
        tgt_idx    = 0;
        redir_pend = 1'b0;
        errors     = 0;
        checks     = 0;
        drain      = 0;
        load_tables();

        repeat (8) @(posedge clk);
        #1;
        checks++;
        if (wb_en_o !== 1'b0) begin
            $display("[ERROR] %0t wb_en_o expected 0 actual %b", $time, wb_en_o);
            errors++;
        end
        checks++;
        if (pc_o !== `RV_RESET_PC) begin
            $display("[ERROR] %0t pc_o expected %h actual %h", $time, `RV_RESET_PC, pc_o);
            errors++;
        end
        rst_n = 1'b1;

        // a result counts on the edge that is not stalled
        while (drain < DRAIN) begin
            @(posedge clk);
            #1;
            if (wb_en_o && !stall_i) check_writeback();
            if (redir_pend && !stall_i) check_redirect();
            stall_i    = (($random(seed) & 7) == 0);
            redir_pend = redirect_o;
            if (wb_idx == N_EXP) drain++;
        end

        if (wb_idx != N_EXP) begin
            $display("only %0d of %0d expected writebacks were seen", wb_idx, N_EXP);
            errors++;
        end
        if (tgt_idx < N_TGT) begin
            $display("only %0d of %0d expected redirects were seen", tgt_idx, N_TGT);
            errors++;
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
